/* logic/nn_consts.svh */
`ifndef NN_CONSTS_SVH
`define NN_CONSTS_SVH

// ==============================
// Fixed-point word format
// ==============================

// Width of every data word, weight, bias and result
`define NN_WORD_SIZE 16

// Integer bits of the signed Q format, sign bit included
`define NN_INT_BITS 8

// Fractional bits follow from the two above
`define NN_FRAC_BITS (`NN_WORD_SIZE - `NN_INT_BITS)

// ==============================
// Layer geometry
// ==============================

// Length of the input vector seen by every neuron
`define NN_N_INPUTS 8

// One MAC lane per neuron, so this is also the output count
`define NN_N_NEURONS 4

`endif

/* logic/nn_pkg.sv */
`include "nn_consts.svh"

package nn_pkg;

    // Signed data word in the Q(INT_BITS).(FRAC_BITS) format
    typedef logic signed [`NN_WORD_SIZE-1:0] word_t;

    // Double width accumulator, wide enough for the full product of two words
    typedef logic signed [2*`NN_WORD_SIZE-1:0] acc_t;

    // Index types sized from the layer geometry
    typedef logic [$clog2(`NN_N_INPUTS)-1:0]  in_idx_t;
    typedef logic [$clog2(`NN_N_NEURONS)-1:0] neuron_idx_t;

    // Storage selected by a load write
    typedef enum logic [1:0] {
        WR_WEIGHT = 2'd0,
        WR_BIAS   = 2'd1,
        WR_INPUT  = 2'd2
    } wr_target_e;

    // Lane controls, one copy shared by every lane
    typedef struct packed {
        logic clear;
        logic add_bias;
        logic sum_en;
    } lane_ctrl_t;

    // Per-lane operands, mem carries the weight or the bias
    typedef struct packed {
        word_t mem;
        word_t data;
    } lane_operand_t;

    // Single-cycle load strobe for weights, biases and inputs
    typedef struct packed {
        logic        en;
        wr_target_e  target;
        neuron_idx_t neuron_idx;
        in_idx_t     input_idx;
        word_t       word;
    } mem_wr_t;

    // Serialized output stream, one neuron per valid cycle
    typedef struct packed {
        logic        valid;
        neuron_idx_t index;
        word_t       value;
    } result_t;

endpackage

/* logic/saturating_alu.sv */
`timescale 1ns/1ps

// Combinational signed arithmetic that clamps instead of wrapping.
// MODE "add" sums two WIDTH-bit operands.
// MODE "narrow" takes a 2*WIDTH-bit fixed-point value down to WIDTH bits
module saturating_alu #(
    parameter int    WIDTH     = 32,
    parameter int    FRAC_BITS = 8,
    parameter string MODE      = "add",
    // Narrowing consumes a double-width operand
    localparam int   IN_WIDTH  = (MODE == "narrow") ? 2 * WIDTH : WIDTH
) (
    input  logic signed [IN_WIDTH-1:0] a_i,
    input  logic signed [IN_WIDTH-1:0] b_i,
    output logic signed [WIDTH-1:0]    data_o
);

    // Clamp limits of the output width
    localparam logic signed [WIDTH-1:0] MAX_VAL = {1'b0, {(WIDTH-1){1'b1}}};
    localparam logic signed [WIDTH-1:0] MIN_VAL = {1'b1, {(WIDTH-1){1'b0}}};

    if (MODE == "narrow") begin : g_narrow

        // ==============================
        // Narrowing path
        // ==============================

        logic signed [IN_WIDTH-1:0]    shifted;
        logic        [IN_WIDTH-WIDTH:0] upper;
        logic                           fits;

        // Drop the extra fractional bits while keeping the sign
        assign shifted = a_i >>> FRAC_BITS;

        // The top bits plus the new sign bit must all match for the value to fit
        assign upper = shifted[IN_WIDTH-1:WIDTH-1];
        assign fits  = (&upper) | ~(|upper);

        // The sign of the wide value tells which way to clamp
        always_comb begin
            if (fits) begin
                data_o = shifted[WIDTH-1:0];
            end else if (a_i[IN_WIDTH-1]) begin
                data_o = MIN_VAL;
            end else begin
                data_o = MAX_VAL;
            end
        end

    end else begin : g_add

        // ==============================
        // Saturating adder
        // ==============================

        logic signed [WIDTH-1:0] raw_sum;
        logic                    overflow;

        assign raw_sum = a_i + b_i;

        // Overflow only when both operands share a sign that the sum lost
        assign overflow = (a_i[WIDTH-1] == b_i[WIDTH-1]) &&
                          (raw_sum[WIDTH-1] != a_i[WIDTH-1]);

        always_comb begin
            if (!overflow) begin
                data_o = raw_sum;
            end else if (a_i[WIDTH-1]) begin
                // Two negatives ran past the bottom
                data_o = MIN_VAL;
            end else begin
                data_o = MAX_VAL;
            end
        end

    end

endmodule

/* logic/neuron_mac.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

// One neuron lane. Accumulates bias and weighted inputs in double width
// and presents the narrowed, clamped sum as a word
module neuron_mac (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  nn_pkg::lane_ctrl_t    ctrl_i,
    input  nn_pkg::lane_operand_t operand_i,
    output nn_pkg::word_t         data_o
);

    localparam int FRAC_BITS = `NN_FRAC_BITS;

    nn_pkg::acc_t acc_q;
    nn_pkg::acc_t acc_sum;
    nn_pkg::acc_t addend;
    nn_pkg::acc_t product;
    nn_pkg::acc_t bias_scaled;

    // ==============================
    // Addend selection
    // ==============================

    // Full signed product of the sign-extended operands, it always fits
    assign product = nn_pkg::acc_t'(operand_i.mem) * nn_pkg::acc_t'(operand_i.data);

    // Bias moves up into product format so both terms share a binary point
    assign bias_scaled = nn_pkg::acc_t'(operand_i.mem) <<< FRAC_BITS;

    assign addend = ctrl_i.add_bias ? bias_scaled : product;

    saturating_alu #(
        .WIDTH    (2 * `NN_WORD_SIZE),
        .FRAC_BITS(FRAC_BITS),
        .MODE     ("add")
    ) i_acc_add (
        .a_i   (acc_q),
        .b_i   (addend),
        .data_o(acc_sum)
    );

    // ==============================
    // Accumulator
    // ==============================

    // Clear wins over a sum in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i || ctrl_i.clear) begin
            acc_q <= '0;
        end else if (ctrl_i.sum_en) begin
            acc_q <= acc_sum;
        end
    end

    // Output follows the register without an extra stage
    saturating_alu #(
        .WIDTH    (`NN_WORD_SIZE),
        .FRAC_BITS(FRAC_BITS),
        .MODE     ("narrow")
    ) i_out_narrow (
        .a_i   (acc_q),
        .b_i   ('0),
        .data_o(data_o)
    );

endmodule

/* logic/layer_sequencer.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

// Holds the layer parameters and the input vector and walks every lane
// through clear, bias and one accumulate per input
module layer_sequencer (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  nn_pkg::mem_wr_t       wr_i,
    output nn_pkg::lane_ctrl_t    lane_ctrl_o,
    output nn_pkg::lane_operand_t operand_o [`NN_N_NEURONS],
    output logic                  calc_done_o,
    output logic                  busy_o
);

    // Drain runs one capture edge plus one edge per result
    localparam int DRAIN_LAST = `NN_N_NEURONS + 1;
    localparam int DRAIN_W    = $clog2(DRAIN_LAST + 1);
    localparam nn_pkg::in_idx_t LAST_IN = nn_pkg::in_idx_t'(`NN_N_INPUTS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,
        S_BIAS,
        S_ACCUM,
        S_DRAIN
    } state_e;

    state_e                state_q;
    nn_pkg::in_idx_t       in_cnt_q;
    nn_pkg::in_idx_t       ld_idx;
    logic [DRAIN_W-1:0]    drain_cnt_q;
    nn_pkg::lane_ctrl_t    ctrl_q;
    nn_pkg::lane_operand_t operand_q [`NN_N_NEURONS];
    logic                  calc_done_q;
    logic                  busy_q;

    nn_pkg::word_t weight_q [`NN_N_NEURONS][`NN_N_INPUTS];
    nn_pkg::word_t bias_q   [`NN_N_NEURONS];
    nn_pkg::word_t input_q  [`NN_N_INPUTS];

    // ==============================
    // Parameter and input storage
    // ==============================

    // Loads are locked out for the whole frame so operands stay stable
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int n = 0; n < `NN_N_NEURONS; n++) begin
                bias_q[n] <= '0;
                for (int i = 0; i < `NN_N_INPUTS; i++) begin
                    weight_q[n][i] <= '0;
                end
            end
            for (int i = 0; i < `NN_N_INPUTS; i++) begin
                input_q[i] <= '0;
            end
        end else if (wr_i.en && !busy_q) begin
            case (wr_i.target)
                nn_pkg::WR_WEIGHT: weight_q[wr_i.neuron_idx][wr_i.input_idx] <= wr_i.word;
                nn_pkg::WR_BIAS:   bias_q[wr_i.neuron_idx] <= wr_i.word;
                nn_pkg::WR_INPUT:  input_q[wr_i.input_idx] <= wr_i.word;
                default: ;
            endcase
        end
    end

    // ==============================
    // Frame FSM
    // ==============================

    // Input slot loaded on this edge, the bias step starts the walk at zero
    assign ld_idx = (state_q == S_BIAS) ? '0 : in_cnt_q + 1'b1;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= S_IDLE;
            in_cnt_q    <= '0;
            drain_cnt_q <= '0;
            ctrl_q      <= '0;
            calc_done_q <= 1'b0;
            busy_q      <= 1'b0;
        end else begin
            // Controls and the done flag are single-cycle unless set below
            ctrl_q      <= '0;
            calc_done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q      <= S_CLEAR;
                        ctrl_q.clear <= 1'b1;
                        busy_q       <= 1'b1;
                    end
                end
                S_CLEAR: begin
                    state_q         <= S_BIAS;
                    ctrl_q.add_bias <= 1'b1;
                    ctrl_q.sum_en   <= 1'b1;
                end
                S_BIAS: begin
                    state_q       <= S_ACCUM;
                    ctrl_q.sum_en <= 1'b1;
                    in_cnt_q      <= ld_idx;
                end
                S_ACCUM: begin
                    // in_cnt_q names the slot the lanes add on this edge
                    if (in_cnt_q == LAST_IN) begin
                        state_q     <= S_DRAIN;
                        calc_done_q <= 1'b1;
                        drain_cnt_q <= '0;
                    end else begin
                        ctrl_q.sum_en <= 1'b1;
                        in_cnt_q      <= ld_idx;
                    end
                end
                S_DRAIN: begin
                    // Stay busy until the drain has shown its last result
                    if (drain_cnt_q == DRAIN_W'(DRAIN_LAST)) begin
                        state_q <= S_IDLE;
                        busy_q  <= 1'b0;
                    end else begin
                        drain_cnt_q <= drain_cnt_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Operands are registered alongside the controls they pair with
    always_ff @(posedge clk_i) begin
        for (int n = 0; n < `NN_N_NEURONS; n++) begin
            if (state_q == S_CLEAR) begin
                operand_q[n].mem <= bias_q[n];
            end else if (state_q == S_BIAS || state_q == S_ACCUM) begin
                operand_q[n].mem  <= weight_q[n][ld_idx];
                operand_q[n].data <= input_q[ld_idx];
            end
        end
    end

    assign lane_ctrl_o = ctrl_q;
    assign operand_o   = operand_q;
    assign calc_done_o = calc_done_q;
    assign busy_o      = busy_q;

endmodule

/* logic/result_drain.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

// Snapshots every lane at the end of a frame, applies ReLU and
// sends the values out one per cycle in lane order
module result_drain (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            calc_done_i,
    input  nn_pkg::word_t   lane_data_i [`NN_N_NEURONS],
    output nn_pkg::result_t result_o
);

    localparam nn_pkg::neuron_idx_t LAST_IDX = nn_pkg::neuron_idx_t'(`NN_N_NEURONS - 1);

    nn_pkg::word_t       hold_q [`NN_N_NEURONS];
    nn_pkg::neuron_idx_t out_idx_q;
    logic                active_q;
    logic                valid_q;
    nn_pkg::neuron_idx_t index_q;
    nn_pkg::word_t       value_q;

    // ==============================
    // Capture with ReLU
    // ==============================

    // All lanes are taken on the same edge, negatives become zero here
    always_ff @(posedge clk_i) begin
        if (calc_done_i) begin
            for (int n = 0; n < `NN_N_NEURONS; n++) begin
                hold_q[n] <= lane_data_i[n][`NN_WORD_SIZE-1] ? '0 : lane_data_i[n];
            end
        end
    end

    // ==============================
    // Serializer
    // ==============================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active_q  <= 1'b0;
            out_idx_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (calc_done_i) begin
                active_q  <= 1'b1;
                out_idx_q <= '0;
            end else if (active_q) begin
                valid_q   <= 1'b1;
                out_idx_q <= out_idx_q + 1'b1;
                // Last lane goes out on this edge
                if (out_idx_q == LAST_IDX) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    // Payload only matters while valid is high
    always_ff @(posedge clk_i) begin
        if (active_q && !calc_done_i) begin
            index_q <= out_idx_q;
            value_q <= hold_q[out_idx_q];
        end
    end

    assign result_o.valid = valid_q;
    assign result_o.index = index_q;
    assign result_o.value = value_q;

endmodule

/* logic/dense_layer.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

// Fully connected layer: sequencer, one MAC lane per neuron and the drain
module dense_layer (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            start_i,
    input  nn_pkg::mem_wr_t wr_i,
    output nn_pkg::result_t result_o,
    output logic            busy_o
);

    // ==============================
    // Internal wiring
    // ==============================

    // Shared controls and per-lane operands from the sequencer
    nn_pkg::lane_ctrl_t    lane_ctrl;
    nn_pkg::lane_operand_t lane_operand [`NN_N_NEURONS];

    // Narrowed lane sums read by the drain
    nn_pkg::word_t lane_data [`NN_N_NEURONS];

    // End of frame pulse
    logic calc_done;

    layer_sequencer i_sequencer (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .start_i    (start_i),
        .wr_i       (wr_i),
        .lane_ctrl_o(lane_ctrl),
        .operand_o  (lane_operand),
        .calc_done_o(calc_done),
        .busy_o     (busy_o)
    );

    // All lanes run in lockstep off the same controls
    for (genvar n = 0; n < `NN_N_NEURONS; n++) begin : g_lane
        neuron_mac i_mac (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .ctrl_i   (lane_ctrl),
            .operand_i(lane_operand[n]),
            .data_o   (lane_data[n])
        );
    end

    result_drain i_drain (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .calc_done_i(calc_done),
        .lane_data_i(lane_data),
        .result_o   (result_o)
    );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

// Free running testbench clock with a reset held for the first few edges
module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 2
) (
    output logic clk_o,
    output logic reset_o
);

    // 8 ns period from two half periods
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset drops on a rising edge like every other driven input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

/* dv/dense_layer_tb.sv */
`timescale 1ns/1ps
`include "nn_consts.svh"

module dense_layer_tb;

    localparam int FRAC        = `NN_FRAC_BITS;
    localparam int SMALL_BITS  = 10;
    localparam int LATENCY     = `NN_N_INPUTS + 5;
    localparam int FRAMES      = 10;
    localparam int WRITES      = `NN_N_NEURONS * `NN_N_INPUTS + `NN_N_NEURONS + `NN_N_INPUTS;
    localparam int TIMEOUT_CYCLES = FRAMES * (`NN_N_INPUTS + `NN_N_NEURONS + 8)
                                  + FRAMES * (WRITES + 1) + 200;
    localparam nn_pkg::word_t WORD_MAX = {1'b0, {(`NN_WORD_SIZE-1){1'b1}}};
    localparam nn_pkg::word_t WORD_MIN = {1'b1, {(`NN_WORD_SIZE-1){1'b0}}};
    localparam longint ACC_MAX = (longint'(1) <<< (2 * `NN_WORD_SIZE - 1)) - 1;
    localparam longint ACC_MIN = -(longint'(1) <<< (2 * `NN_WORD_SIZE - 1));
    localparam nn_pkg::neuron_idx_t LAST_N = nn_pkg::neuron_idx_t'(`NN_N_NEURONS - 1);

    logic            clk;
    logic            reset;
    logic            start;
    nn_pkg::mem_wr_t wr;
    nn_pkg::result_t result;
    logic            busy;

    // Reference copies of the layer storage that only accepted writes update
    nn_pkg::word_t weight_m [`NN_N_NEURONS][`NN_N_INPUTS];
    nn_pkg::word_t bias_m   [`NN_N_NEURONS];
    nn_pkg::word_t input_m  [`NN_N_INPUTS];

    nn_pkg::result_t exp_q [$];
    nn_pkg::result_t exp_head;
    logic            exp_avail;
    int              cycle_q;
    int              start_cycle_q;
    logic [31:0]     lfsr_state;

    tb_clock_gen #(.HALF_PERIOD_NS(4), .RESET_CYCLES(2)) i_clock (
        .clk_o  (clk),
        .reset_o(reset)
    );

    dense_layer i_dut (
        .clk_i   (clk),
        .reset_i (reset),
        .start_i (start),
        .wr_i    (wr),
        .result_o(result),
        .busy_o  (busy)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Stopped at the first error");
    endtask

    // ==============================
    // Random source and reference model
    // ==============================

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Two's complement value of the given width sign extended to a word
    function automatic nn_pkg::word_t rand_signed(input int count);
        logic [31:0] raw;
        int          value;
        raw   = rand_bits(count);
        value = int'(raw);
        if (raw[count-1]) value = value - (1 << count);
        return nn_pkg::word_t'(value);
    endfunction

    function automatic nn_pkg::word_t rand_extreme();
        case (rand_bits(2))
            0: return WORD_MAX;
            1: return WORD_MIN;
            2: return '0;
            default: return rand_signed(SMALL_BITS);
        endcase
    endfunction

    function automatic longint clamp(input longint v, input longint lo, input longint hi);
        if (v > hi) return hi;
        if (v < lo) return lo;
        return v;
    endfunction

    // Adds the scaled bias and each product with saturation and narrows the sum before ReLU
    function automatic nn_pkg::word_t neuron_ref(input int n);
        longint acc;
        longint narrowed;
        acc = clamp(longint'(bias_m[n]) <<< FRAC, ACC_MIN, ACC_MAX);
        for (int i = 0; i < `NN_N_INPUTS; i++) begin
            acc = clamp(acc + longint'(weight_m[n][i]) * longint'(input_m[i]),
                        ACC_MIN, ACC_MAX);
        end
        narrowed = clamp(acc >>> FRAC, longint'(WORD_MIN), longint'(WORD_MAX));
        if (narrowed < 0) narrowed = 0;
        return nn_pkg::word_t'(narrowed);
    endfunction

    // Tracks accepted writes and starts, and pops one expected entry per result
    always @(posedge clk) begin
        nn_pkg::result_t item;
        if (reset) begin
            for (int n = 0; n < `NN_N_NEURONS; n++) begin
                bias_m[n] = '0;
                for (int i = 0; i < `NN_N_INPUTS; i++) weight_m[n][i] = '0;
            end
            for (int i = 0; i < `NN_N_INPUTS; i++) input_m[i] = '0;
            exp_q.delete();
        end else begin
            if (wr.en && !busy) begin
                case (wr.target)
                    nn_pkg::WR_WEIGHT: weight_m[wr.neuron_idx][wr.input_idx] = wr.word;
                    nn_pkg::WR_BIAS:   bias_m[wr.neuron_idx] = wr.word;
                    nn_pkg::WR_INPUT:  input_m[wr.input_idx] = wr.word;
                    default: ;
                endcase
            end
            if (start && !busy) begin
                start_cycle_q <= cycle_q;
                for (int n = 0; n < `NN_N_NEURONS; n++) begin
                    item.valid = 1'b1;
                    item.index = nn_pkg::neuron_idx_t'(n);
                    item.value = neuron_ref(n);
                    exp_q.push_back(item);
                end
            end
            if (result.valid && exp_q.size() != 0) void'(exp_q.pop_front());
        end
        exp_avail = (exp_q.size() != 0);
        exp_head  = exp_avail ? exp_q[0] : '0;
    end

    // ==============================
    // Checks
    // ==============================

    always @(posedge clk) begin
        cycle_q <= cycle_q + 1;
        if (cycle_q >= TIMEOUT_CYCLES) begin
            stop_with_error("Timeout: the run went past its cycle limit without finishing");
        end
    end

    after_reset: assert property (@(posedge clk) reset |=> !busy && !result.valid)
        else stop_with_error("busy_o or result_o.valid was active right after reset");

    no_spurious: assert property (@(posedge clk) disable iff (reset)
        result.valid |-> exp_avail)
        else stop_with_error("A result came out with no frame pending");

    value_match: assert property (@(posedge clk) disable iff (reset)
        result.valid |-> result.value == exp_head.value)
        else stop_with_error($sformatf("[FAIL] t=%0t result_o.value expected %0d got %0d",
            $time, $sampled(exp_head.value), $sampled(result.value)));

    index_match: assert property (@(posedge clk) disable iff (reset)
        result.valid |-> result.index == exp_head.index)
        else stop_with_error($sformatf("[FAIL] t=%0t result_o.index expected %0d got %0d",
            $time, $sampled(exp_head.index), $sampled(result.index)));

    // Cycles counted from the edge that accepted the start
    first_latency: assert property (@(posedge clk) disable iff (reset)
        result.valid && result.index == '0 |-> (cycle_q - start_cycle_q) == LATENCY)
        else stop_with_error($sformatf("[FAIL] t=%0t result_o.valid latency expected %0d got %0d",
            $time, LATENCY, $sampled(cycle_q) - $sampled(start_cycle_q)));

    no_gap: assert property (@(posedge clk) disable iff (reset)
        result.valid && result.index != LAST_N |=> result.valid)
        else stop_with_error("The result stream had a gap before the last neuron");

    busy_with_results: assert property (@(posedge clk) disable iff (reset)
        result.valid |-> busy)
        else stop_with_error($sformatf("[FAIL] t=%0t busy_o expected 1 got 0", $time));

    busy_falls: assert property (@(posedge clk) disable iff (reset)
        result.valid && result.index == LAST_N |=> !busy)
        else stop_with_error($sformatf("[FAIL] t=%0t busy_o expected 0 got 1", $time));

    idle_holds: assert property (@(posedge clk) disable iff (reset)
        !busy && !start |=> !busy)
        else stop_with_error("busy_o rose without a start pulse");

    // An accepted start raises busy on the very next cycle
    busy_rises: assert property (@(posedge clk) disable iff (reset)
        start && !busy |=> busy)
        else stop_with_error($sformatf("[FAIL] t=%0t busy_o after start expected 1 got 0",
            $time));

    // ==============================
    // Stimulus
    // ==============================

    task automatic write_word(input nn_pkg::wr_target_e tgt, input int n, input int i,
                              input nn_pkg::word_t word);
        @(posedge clk);
        wr <= '{en: 1'b1, target: tgt, neuron_idx: nn_pkg::neuron_idx_t'(n),
                input_idx: nn_pkg::in_idx_t'(i), word: word};
    endtask

    task automatic end_writes();
        @(posedge clk);
        wr.en <= 1'b0;
    endtask

    // Mode 0 loads small random values and mode 1 random extremes
    // Mode 2 keeps the weights small and gives the biases large opposite signs
    task automatic load_random(input int mode);
        for (int n = 0; n < `NN_N_NEURONS; n++) begin
            for (int i = 0; i < `NN_N_INPUTS; i++) begin
                write_word(nn_pkg::WR_WEIGHT, n, i,
                           (mode == 1) ? rand_extreme() : rand_signed(SMALL_BITS));
            end
        end
        for (int n = 0; n < `NN_N_NEURONS; n++) begin
            if (mode == 2) write_word(nn_pkg::WR_BIAS, n, 0, n[0] ? 16'sh3000 : -16'sh3000);
            else if (mode == 1) write_word(nn_pkg::WR_BIAS, n, 0, rand_extreme());
            else write_word(nn_pkg::WR_BIAS, n, 0, rand_signed(SMALL_BITS));
        end
        for (int i = 0; i < `NN_N_INPUTS; i++) begin
            write_word(nn_pkg::WR_INPUT, 0, i,
                       (mode == 1) ? rand_extreme() : rand_signed(SMALL_BITS));
        end
        end_writes();
    endtask

    task automatic load_constant(input nn_pkg::word_t w, input nn_pkg::word_t x,
                                 input nn_pkg::word_t b);
        for (int n = 0; n < `NN_N_NEURONS; n++) begin
            for (int i = 0; i < `NN_N_INPUTS; i++) write_word(nn_pkg::WR_WEIGHT, n, i, w);
            write_word(nn_pkg::WR_BIAS, n, 0, b);
        end
        for (int i = 0; i < `NN_N_INPUTS; i++) write_word(nn_pkg::WR_INPUT, 0, i, x);
        end_writes();
    endtask

    // Three maximal products saturate high and two negative ones pull the sum back into range
    task automatic load_mixed_extremes();
        for (int n = 0; n < `NN_N_NEURONS; n++) begin
            for (int i = 0; i < `NN_N_INPUTS; i++) begin
                write_word(nn_pkg::WR_WEIGHT, n, i,
                           (i < 3) ? WORD_MAX : (i < 5) ? WORD_MIN : '0);
            end
            write_word(nn_pkg::WR_BIAS, n, 0, '0);
        end
        for (int i = 0; i < `NN_N_INPUTS; i++) begin
            write_word(nn_pkg::WR_INPUT, 0, i, (i < 5) ? WORD_MAX : '0);
        end
        end_writes();
    endtask

    task automatic run_frame();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do @(posedge clk); while (!busy);
        do @(posedge clk); while (busy);
    endtask

    // Writes and a second start land while busy and must leave no trace
    task automatic run_frame_with_noise();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        wr <= '{en: 1'b1, target: nn_pkg::WR_WEIGHT, neuron_idx: '0,
                input_idx: nn_pkg::in_idx_t'(`NN_N_INPUTS - 1), word: 16'sh4000};
        @(posedge clk);
        wr <= '{en: 1'b1, target: nn_pkg::WR_INPUT, neuron_idx: '0,
                input_idx: nn_pkg::in_idx_t'(`NN_N_INPUTS - 1), word: WORD_MAX};
        start <= 1'b1;
        @(posedge clk);
        wr.en <= 1'b0;
        start <= 1'b0;
        do @(posedge clk); while (busy);
        repeat (6) @(posedge clk);
    endtask

    initial begin
        start      = 1'b0;
        wr         = '0;
        cycle_q    = 0;
        start_cycle_q = 0;
        lfsr_state = 32'hd38e;
        do @(posedge clk); while (reset);
        // Idle stretch after reset where busy and the result stream must stay low
        repeat (6) @(posedge clk);

        repeat (3) begin
            load_random(0);
            run_frame();
        end
        load_constant(WORD_MAX, WORD_MAX, WORD_MAX);
        run_frame();
        load_mixed_extremes();
        run_frame();
        load_random(2);
        run_frame();
        repeat (2) begin
            load_random(1);
            run_frame();
        end
        load_random(0);
        run_frame_with_noise();
        // Same storage again where an accepted stray write would show up
        run_frame();
        repeat (8) @(posedge clk);

        if (exp_q.size() != 0 || busy) begin
            stop_with_error("The run ended with expected results still pending");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

/* src.f */
+incdir+logic
logic/nn_pkg.sv
logic/saturating_alu.sv
logic/neuron_mac.sv
logic/layer_sequencer.sv
logic/result_drain.sv
logic/dense_layer.sv
dv/tb_clock_gen.sv
dv/dense_layer_tb.sv

/* Bender.yml */
package:
  name: dense_layer

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/nn_pkg.sv
      - logic/saturating_alu.sv
      - logic/neuron_mac.sv
      - logic/layer_sequencer.sv
      - logic/result_drain.sv
      - logic/dense_layer.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_clock_gen.sv
      - dv/dense_layer_tb.sv
